/* design/mem_access_pkg.sv */
package mem_access_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 32;
	localparam int queue_depth = 2; // Also the credit count after reset.

	typedef logic [addr_width-1:0] cpu_addr_t;
	typedef logic [data_width-1:0] mem_data_t;

	// Holds 0 to queue_depth.
	typedef logic [1:0] credit_t;

	typedef enum logic
	{
		rd_idle,
		rd_wait_mem
	} rd_port_state_t;

	typedef enum logic
	{
		grant_rd,
		grant_wr
	} grant_t;

endpackage

/* design/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
	import mem_access_pkg::*;

	logic cmd_valid;
	cpu_addr_t cmd_addr;
	mem_data_t cmd_wdata;
	logic credit_ret; // One pulse per popped command.
	logic rsp_valid;
	mem_data_t rsp_data;

	modport port
	(
		output cmd_valid, cmd_addr, cmd_wdata,
		input credit_ret, rsp_valid, rsp_data
	);

	modport guard
	(
		input cmd_valid, cmd_addr, cmd_wdata,
		output credit_ret, rsp_valid, rsp_data
	);

endinterface

/* design/data_mem.sv */
`timescale 1ns/1ps

module data_mem
(
	input logic clk,
	input logic en,
	input logic we,
	input mem_access_pkg::cpu_addr_t addr,
	input mem_access_pkg::mem_data_t wdata,
	output mem_access_pkg::mem_data_t rdata
);
	import mem_access_pkg::*;

	mem_data_t mem [2**addr_width];

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // One cycle of read latency.
		end
	end

endmodule

/* design/mem_read_port.sv */
`timescale 1ns/1ps

module mem_read_port
(
	input logic clk,
	input logic rst_n,
	input logic req,
	input mem_access_pkg::cpu_addr_t addr,
	output logic busy,
	output logic valid,
	output mem_access_pkg::mem_data_t data,
	mem_bus_if.port bus
);
	import mem_access_pkg::*;

	rd_port_state_t state;
	credit_t credits;
	logic issue;

	assign issue = req && (state == rd_idle) && (credits != '0);
	assign busy = (state == rd_wait_mem) || (credits == '0);

	assign bus.cmd_valid = issue;
	assign bus.cmd_addr = addr;
	assign bus.cmd_wdata = '0; // Reads carry no data.

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= credit_t'(queue_depth);
		else
		begin
			case ({issue, bus.credit_ret})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= rd_idle;
			valid <= 1'b0;
		end
		else
		begin
			valid <= 1'b0;
			case (state)
				rd_idle:
				begin
					if (issue)
						state <= rd_wait_mem;
				end
				rd_wait_mem:
				begin
					if (bus.rsp_valid)
					begin
						state <= rd_idle;
						valid <= 1'b1;
					end
				end
				default: state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == rd_wait_mem && bus.rsp_valid)
			data <= bus.rsp_data; // Held until the next read.
	end

endmodule

/* design/mem_write_port.sv */
`timescale 1ns/1ps

module mem_write_port
(
	input logic clk,
	input logic rst_n,
	input logic req,
	input mem_access_pkg::cpu_addr_t addr,
	input mem_access_pkg::mem_data_t wdata,
	output logic busy,
	output logic done,
	mem_bus_if.port bus
);
	import mem_access_pkg::*;

	credit_t credits;
	logic issue;

	assign busy = (credits == '0);
	assign issue = req && !busy;

	// Posted write, forwarded in the cycle it is accepted.
	assign bus.cmd_valid = issue;
	assign bus.cmd_addr = addr;
	assign bus.cmd_wdata = wdata;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= credit_t'(queue_depth);
		else
		begin
			case ({issue, bus.credit_ret})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Queue pops are in order, so commits come in acceptance order.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= bus.credit_ret;
	end

endmodule

/* design/mem_bus_guard.sv */
`timescale 1ns/1ps

module mem_bus_guard
(
	input logic clk,
	input logic rst_n,
	mem_bus_if.guard rd_bus,
	mem_bus_if.guard wr_bus,
	output logic mem_en,
	output logic mem_we,
	output mem_access_pkg::cpu_addr_t mem_addr,
	output mem_access_pkg::mem_data_t mem_wdata,
	input mem_access_pkg::mem_data_t mem_rdata
);
	import mem_access_pkg::*;

	// Index 0 is the read queue, index 1 the write queue.
	cpu_addr_t cmd_addr [2];
	cpu_addr_t q_addr [2][queue_depth];
	mem_data_t q_wdata [queue_depth]; // Write queue only.
	logic [$clog2(queue_depth)-1:0] wr_ptr [2];
	logic [$clog2(queue_depth)-1:0] rd_ptr [2];
	credit_t q_count [2];
	logic [1:0] push;
	logic [1:0] pop;
	logic [1:0] nonempty;
	logic pick_wr;
	grant_t last_grant;
	logic [1:0] credit_ret_q;
	logic rd_pop_d1;
	logic rsp_valid_q;
	mem_data_t rsp_data_q;

	assign push = {wr_bus.cmd_valid, rd_bus.cmd_valid};
	assign cmd_addr[0] = rd_bus.cmd_addr;
	assign cmd_addr[1] = wr_bus.cmd_addr;

	assign nonempty = {q_count[1] != '0, q_count[0] != '0};
	assign pick_wr = nonempty[1] && (!nonempty[0] || last_grant == grant_rd); // Round-robin.
	assign pop = {pick_wr, nonempty[0] && !pick_wr};

	assign mem_en = |pop;
	assign mem_we = pop[1];
	assign mem_addr = pop[1] ? q_addr[1][rd_ptr[1]] : q_addr[0][rd_ptr[0]];
	assign mem_wdata = q_wdata[rd_ptr[1]];

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (push[i])
				q_addr[i][wr_ptr[i]] <= cmd_addr[i];
		end
		if (push[1])
			q_wdata[wr_ptr[1]] <= wr_bus.cmd_wdata;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 2; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				q_count[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (push[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (pop[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				case ({push[i], pop[i]})
					2'b10: q_count[i] <= q_count[i] + 1'b1;
					2'b01: q_count[i] <= q_count[i] - 1'b1;
					default: q_count[i] <= q_count[i];
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_grant <= grant_wr; // Read wins the first tie.
			credit_ret_q <= 2'b00;
			rd_pop_d1 <= 1'b0;
			rsp_valid_q <= 1'b0;
		end
		else
		begin
			if (pop[0])
				last_grant <= grant_rd;
			else if (pop[1])
				last_grant <= grant_wr;
			credit_ret_q <= pop;
			rd_pop_d1 <= pop[0]; // Memory data arrives the cycle after the pop.
			rsp_valid_q <= rd_pop_d1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_pop_d1)
			rsp_data_q <= mem_rdata;
	end

	assign rd_bus.credit_ret = credit_ret_q[0];
	assign wr_bus.credit_ret = credit_ret_q[1];
	assign rd_bus.rsp_valid = rsp_valid_q;
	assign rd_bus.rsp_data = rsp_data_q;
	assign wr_bus.rsp_valid = 1'b0; // Writes get no data back.
	assign wr_bus.rsp_data = '0;

endmodule

/* design/mem_access_top.sv */
`timescale 1ns/1ps

module mem_access_top
(
	input logic clk,
	input logic rst_n,
	input logic rd_req,
	input mem_access_pkg::cpu_addr_t rd_addr,
	input logic wr_req,
	input mem_access_pkg::cpu_addr_t wr_addr,
	input mem_access_pkg::mem_data_t wr_data,
	output logic rd_busy,
	output logic rd_valid,
	output mem_access_pkg::mem_data_t rd_data,
	output logic wr_busy,
	output logic wr_done
);
	import mem_access_pkg::*;

	logic mem_en;
	logic mem_we;
	cpu_addr_t mem_addr;
	mem_data_t mem_wdata;
	mem_data_t mem_rdata;

	mem_bus_if rd_bus ();
	mem_bus_if wr_bus ();

	mem_read_port mem_read_port_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(rd_req),
		.addr(rd_addr),
		.busy(rd_busy),
		.valid(rd_valid),
		.data(rd_data),
		.bus(rd_bus.port)
	);

	mem_write_port mem_write_port_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(wr_req),
		.addr(wr_addr),
		.wdata(wr_data),
		.busy(wr_busy),
		.done(wr_done),
		.bus(wr_bus.port)
	);

	mem_bus_guard mem_bus_guard_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.rd_bus(rd_bus.guard),
		.wr_bus(wr_bus.guard),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	data_mem data_mem_inst
	(
		.clk(clk),
		.en(mem_en),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

/* tb/mem_access_chk.sv */
`timescale 1ns/1ps

module mem_access_chk
(
	input logic clk,
	input logic rst_n,
	input logic [1:0] push,
	input mem_access_pkg::credit_t rd_count,
	input mem_access_pkg::credit_t wr_count,
	input logic [1:0] credit_ret,
	input logic rd_pop,
	input logic rsp_valid
);
	import mem_access_pkg::*;

	int fail_count;

	rd_push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		push[0] |-> rd_count != credit_t'(queue_depth))
	else
	begin
		fail_count++;
		$error("Read queue pushed while full.");
	end

	wr_push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		push[1] |-> wr_count != credit_t'(queue_depth))
	else
	begin
		fail_count++;
		$error("Write queue pushed while full.");
	end

	one_credit_ret: assert property (@(posedge clk) disable iff (!rst_n)
		credit_ret != 2'b11)
	else
	begin
		fail_count++;
		$error("Credit returned to both ports in one cycle.");
	end

	rsp_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
		rd_pop |-> ##2 rsp_valid)
	else
	begin
		fail_count++;
		$error("Read response missing two cycles after the pop.");
	end

	rsp_only_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |-> $past(rd_pop, 2))
	else
	begin
		fail_count++;
		$error("Read response without a read pop two cycles before.");
	end

endmodule

bind mem_bus_guard mem_access_chk mem_access_chk_inst
(
	.clk(clk),
	.rst_n(rst_n),
	.push(push),
	.rd_count(q_count[0]),
	.wr_count(q_count[1]),
	.credit_ret(credit_ret_q),
	.rd_pop(pop[0]),
	.rsp_valid(rsp_valid_q)
);

/* tb/tb_mem_access.sv */
`timescale 1ns/1ps

module tb_mem_access;
	import mem_access_pkg::*;

	localparam int max_cycles = 2000;
	localparam int wait_limit = 50;

	logic clk;
	logic rst_n;
	logic rd_req;
	cpu_addr_t rd_addr;
	logic wr_req;
	cpu_addr_t wr_addr;
	mem_data_t wr_data;
	logic rd_busy;
	logic rd_valid;
	mem_data_t rd_data;
	logic wr_busy;
	logic wr_done;

	mem_data_t ref_mem [256];
	bit written [256];
	int wr_accepts;
	int wr_dones;
	int errors;
	int cycle_count;
	logic [15:0] lfsr;

	mem_access_top mem_access_top_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.wr_req(wr_req),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_busy(rd_busy),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.wr_busy(wr_busy),
		.wr_done(wr_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run;
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%0t: %s", $time, what);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]}; // One step per bit.
		end
	endtask

	task automatic record_write(input cpu_addr_t addr, input mem_data_t data);
		ref_mem[addr] = data;
		written[addr] = 1'b1;
		wr_accepts++;
	endtask

	// Holds the request until the write port takes it.
	task automatic post_write(input cpu_addr_t addr, input mem_data_t data);
		int cycles;
		cycles = 0;
		@(posedge clk);
		wr_req <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		@(negedge clk);
		while (wr_busy)
		begin
			cycles++;
			if (cycles > wait_limit)
				report_failure("write port stayed busy and never took the write");
			@(negedge clk);
		end
		record_write(addr, data);
		@(posedge clk);
		wr_req <= 1'b0;
	endtask

	task automatic wait_writes_done;
		int cycles;
		cycles = 0;
		while (wr_dones != wr_accepts)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > wait_limit)
				report_failure("wr_done never came for an accepted write");
		end
	endtask

	task automatic finish_read(input mem_data_t expected);
		int cycles;
		bit got;
		cycles = 0;
		got = 0;
		while (!got)
		begin
			@(negedge clk);
			if (rd_valid)
			begin
				check_value("rd_data", rd_data, expected);
				got = 1;
			end
			else
			begin
				check_value("rd_busy", rd_busy, 1'b1);
				cycles++;
				if (cycles > wait_limit)
					report_failure("rd_valid never came for an accepted read");
			end
		end
	endtask

	task automatic read_and_check(input cpu_addr_t addr, input mem_data_t expected);
		@(posedge clk);
		rd_req <= 1'b1;
		rd_addr <= addr;
		@(negedge clk);
		check_value("rd_busy", rd_busy, 1'b0); // Idle port takes the read now.
		@(posedge clk);
		rd_req <= 1'b0;
		finish_read(expected);
	endtask

	task automatic test_reset_state;
		@(negedge clk);
		check_value("rd_busy", rd_busy, 1'b0);
		check_value("rd_valid", rd_valid, 1'b0);
		check_value("wr_busy", wr_busy, 1'b0);
		check_value("wr_done", wr_done, 1'b0);
	endtask

	task automatic test_write_then_read;
		post_write(8'h05, 32'hA5A5_1234);
		wait_writes_done();
		read_and_check(8'h05, 32'hA5A5_1234);
	endtask

	task automatic test_credit_exhaustion;
		int idx;
		int busy_seen;
		cpu_addr_t base;
		idx = 0;
		busy_seen = 0;
		base = 8'h10;
		for (int c = 0; c < 12; c++)
		begin
			@(posedge clk);
			wr_req <= 1'b1;
			wr_addr <= base + cpu_addr_t'(idx);
			wr_data <= 32'hC000_0000 + idx * 32'h0001_0111;
			@(negedge clk);
			if (wr_busy)
				busy_seen = 1;
			else
			begin
				record_write(wr_addr, wr_data);
				idx++;
			end
		end
		@(posedge clk);
		wr_req <= 1'b0;
		check_value("wr_busy_seen", busy_seen, 1);
		wait_writes_done();
		repeat (4) @(negedge clk); // Catch any stray commit.
		check_value("wr_done_count", wr_dones, wr_accepts);
		for (int i = 0; i < idx; i++)
			read_and_check(base + cpu_addr_t'(i), ref_mem[base + cpu_addr_t'(i)]);
	endtask

	task automatic test_contention;
		mem_data_t old_value;
		old_value = ref_mem[8'h05];
		@(posedge clk);
		rd_req <= 1'b1;
		rd_addr <= 8'h05;
		wr_req <= 1'b1;
		wr_addr <= 8'h06;
		wr_data <= 32'h0BAD_F00D;
		@(negedge clk);
		check_value("rd_busy", rd_busy, 1'b0);
		check_value("wr_busy", wr_busy, 1'b0);
		record_write(wr_addr, wr_data);
		@(posedge clk);
		rd_req <= 1'b0;
		wr_req <= 1'b0;
		finish_read(old_value);
		wait_writes_done();
		read_and_check(8'h06, 32'h0BAD_F00D);
	endtask

	task automatic test_random_traffic;
		logic [31:0] r_op;
		logic [31:0] r_addr;
		logic [31:0] r_data;
		cpu_addr_t addr;
		for (int n = 0; n < 40; n++)
		begin
			random_bits(1, r_op);
			random_bits(4, r_addr);
			addr = 8'h40 | cpu_addr_t'(r_addr[3:0]);
			if (r_op[0] && written[addr])
			begin
				wait_writes_done();
				read_and_check(addr, ref_mem[addr]);
			end
			else
			begin
				random_bits(32, r_data); // Unwritten reads turn into writes.
				post_write(addr, r_data);
			end
		end
		wait_writes_done();
	endtask

	always @(negedge clk)
	begin
		if (rst_n && wr_done)
			wr_dones++;
	end

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= max_cycles)
				report_failure("run did not finish within the cycle limit");
		end
	end

	initial
	begin
		rst_n = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		wr_req = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		wr_accepts = 0;
		wr_dones = 0;
		errors = 0;
		lfsr = 16'd58;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_state();
		test_write_then_read();
		test_credit_exhaustion();
		test_contention();
		test_random_traffic();
		repeat (5) @(posedge clk);
		errors += mem_access_top_inst.mem_bus_guard_inst.mem_access_chk_inst.fail_count;
		if (errors == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("%0d bus guard assertions failed during the run", errors);
			abort_run();
		end
	end

endmodule

/* build.f */
design/mem_access_pkg.sv
design/mem_bus_if.sv
design/data_mem.sv
design/mem_read_port.sv
design/mem_write_port.sv
design/mem_bus_guard.sv
design/mem_access_top.sv
tb/mem_access_chk.sv
tb/tb_mem_access.sv
